// File: src/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath width
`define REG_WIDTH 16
`define SEQ_WIDTH 16  // Debug sequence counter

// Architectural register file
`define ARF_N_REGS 8
`define ARF_ID_WIDTH 3

// Reorder buffer, depth is a power of two
`define ROB_N_ENTRIES 8
`define ROB_ID_WIDTH 3

// Pipelined multiplier depth
`define MUL_STAGES 3

`endif

// File: src/core_pkg.sv
`include "core_cfg.svh"

package core_pkg;

    typedef logic [`REG_WIDTH-1:0] reg_data_t;
    typedef logic [`ARF_ID_WIDTH-1:0] arf_id_t;
    typedef logic [`ROB_ID_WIDTH-1:0] rob_id_t;
    typedef logic [`ROB_ID_WIDTH:0] rob_cnt_t;  // Occupancy, one bit wider than an id
    typedef logic [`SEQ_WIDTH-1:0] seq_t;

    typedef enum logic [1:0] {
        op_li  = 2'd0,
        op_add = 2'd1,
        op_sub = 2'd2,
        op_mul = 2'd3
    } op_e;

    // Source 2 sits in imm[7:5], load-immediate uses all of imm
    typedef struct packed {
        op_e op;
        arf_id_t dst;
        arf_id_t src1;
        logic [7:0] imm;
    } inst_t;

    typedef struct packed {
        arf_id_t dst_arf_id;
        logic reg_ready;
        reg_data_t reg_data;
        seq_t seq;  // Program order tag for waveform debug
    } rob_entry_t;

    typedef struct packed {
        op_e op;
        rob_id_t rob_id;
        reg_data_t src1_data;
        reg_data_t src2_data;
    } issue_t;

    typedef struct packed {
        logic valid;
        rob_id_t rob_id;
        reg_data_t reg_data;
    } wb_t;

    typedef struct packed {
        logic reg_ready;
        reg_data_t reg_data;
    } src_query_t;

    typedef struct packed {
        logic valid;
        rob_id_t rob_id;
        arf_id_t arf_id;
        reg_data_t reg_data;
    } retire_t;

endpackage

// File: src/inst_decode.sv
module inst_decode (
    input  logic clk,
    input  logic reset,

    // Instruction stream, ready/valid
    input  logic instr_valid,
    input  core_pkg::inst_t instr,
    output logic instr_ready,

    // Register file lookup
    output core_pkg::arf_id_t arf_src1_id,
    output core_pkg::arf_id_t arf_src2_id,
    input  logic arf_src1_pending,
    input  logic arf_src2_pending,
    input  core_pkg::rob_id_t arf_src1_tag,
    input  core_pkg::rob_id_t arf_src2_tag,
    input  core_pkg::reg_data_t arf_src1_data,
    input  core_pkg::reg_data_t arf_src2_data,

    // ROB operand reads, indexed by the rename tags
    input  core_pkg::src_query_t rob_query1,
    input  core_pkg::src_query_t rob_query2,

    // ROB dispatch
    input  logic rob_full,
    output logic dispatch,
    output core_pkg::rob_entry_t dispatch_entry,
    input  core_pkg::rob_id_t dispatch_rob_id,

    // Issue to execute units
    output logic alu_issue,
    output logic mul_issue,
    output core_pkg::issue_t issue
);
    core_pkg::op_e op;
    logic uses_srcs;
    logic src1_ok;
    logic src2_ok;
    core_pkg::reg_data_t src1_val;
    core_pkg::reg_data_t src2_val;
    core_pkg::reg_data_t op_a;
    core_pkg::seq_t seq_count;

    assign op = instr.op;
    assign uses_srcs = (op != core_pkg::op_li);

    assign arf_src1_id = instr.src1;
    assign arf_src2_id = instr.imm[7:5];

    // A pending source is usable once its producer has written back
    assign src1_ok = !arf_src1_pending || rob_query1.reg_ready;
    assign src2_ok = !arf_src2_pending || rob_query2.reg_ready;
    assign src1_val = arf_src1_pending ? rob_query1.reg_data : arf_src1_data;
    assign src2_val = arf_src2_pending ? rob_query2.reg_data : arf_src2_data;

    assign instr_ready = !rob_full && (!uses_srcs || (src1_ok && src2_ok));
    assign dispatch = instr_valid && instr_ready;

    // Immediate travels in the first operand slot
    assign op_a = uses_srcs ? src1_val : core_pkg::reg_data_t'(instr.imm);

    assign dispatch_entry = '{
        dst_arf_id: instr.dst,
        reg_ready: 1'b0,
        reg_data: '0,
        seq: seq_count
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            seq_count <= '0;
            alu_issue <= 1'b0;
            mul_issue <= 1'b0;
        end else begin
            if (dispatch) begin
                seq_count <= seq_count + 1'b1;
            end
            alu_issue <= dispatch && (op != core_pkg::op_mul);
            mul_issue <= dispatch && (op == core_pkg::op_mul);
        end
    end

    // Issue bundle is shared by both units, the strobes pick one
    always_ff @(posedge clk) begin
        if (dispatch) begin
            issue <= '{
                op: op,
                rob_id: dispatch_rob_id,
                src1_data: op_a,
                src2_data: src2_val
            };
        end
    end

endmodule

// File: src/reg_file.sv
`include "core_cfg.svh"

module reg_file (
    input  logic clk,
    input  logic reset,

    // Two source lookups from decode
    input  core_pkg::arf_id_t src1_id,
    input  core_pkg::arf_id_t src2_id,
    output logic src1_pending,
    output logic src2_pending,
    output core_pkg::rob_id_t src1_tag,
    output core_pkg::rob_id_t src2_tag,
    output core_pkg::reg_data_t src1_data,
    output core_pkg::reg_data_t src2_data,

    // Rename on dispatch
    input  logic dispatch,
    input  core_pkg::arf_id_t dispatch_arf_id,
    input  core_pkg::rob_id_t dispatch_rob_id,

    // In-order commit from the ROB
    input  core_pkg::retire_t retire_info
);
    core_pkg::reg_data_t regs [`ARF_N_REGS];
    core_pkg::rob_id_t tags [`ARF_N_REGS];
    logic [`ARF_N_REGS-1:0] pending;
    logic tag_match;
    logic redispatch;

    assign src1_pending = pending[src1_id];
    assign src2_pending = pending[src2_id];
    assign src1_tag = tags[src1_id];
    assign src2_tag = tags[src2_id];
    assign src1_data = regs[src1_id];
    assign src2_data = regs[src2_id];

    // Only the youngest producer may clear the pending bit
    assign tag_match = (tags[retire_info.arf_id] == retire_info.rob_id);
    assign redispatch = dispatch && (dispatch_arf_id == retire_info.arf_id);

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
            for (int i = 0; i < `ARF_N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (retire_info.valid) begin
                regs[retire_info.arf_id] <= retire_info.reg_data;
                if (tag_match && !redispatch) begin
                    pending[retire_info.arf_id] <= 1'b0;
                end
            end
            if (dispatch) begin
                pending[dispatch_arf_id] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            tags[dispatch_arf_id] <= dispatch_rob_id;  // Newest producer wins
        end
    end

endmodule

// File: src/rob.sv
`include "core_cfg.svh"

module rob (
    input  logic clk,
    input  logic reset,

    // Dispatch at the tail
    input  logic dispatch,
    input  core_pkg::rob_entry_t dispatch_entry,
    output core_pkg::rob_id_t dispatch_rob_id,
    output logic rob_full,

    // Operand reads for decode
    input  core_pkg::rob_id_t query1_id,
    input  core_pkg::rob_id_t query2_id,
    output core_pkg::src_query_t query1,
    output core_pkg::src_query_t query2,

    // Writeback, one port per execute unit
    input  core_pkg::wb_t alu_wb,
    input  core_pkg::wb_t mul_wb,

    // Commit to the register file, which never stalls
    output core_pkg::retire_t retire_info
);
    core_pkg::rob_entry_t entries [`ROB_N_ENTRIES];
    core_pkg::rob_id_t head;
    core_pkg::rob_id_t tail;
    core_pkg::rob_cnt_t count;
    core_pkg::rob_entry_t head_entry;
    core_pkg::rob_entry_t q1_entry;
    core_pkg::rob_entry_t q2_entry;
    logic rob_empty;
    logic retire;

    assign head_entry = entries[head];
    assign q1_entry = entries[query1_id];
    assign q2_entry = entries[query2_id];

    assign rob_empty = (count == '0);
    assign rob_full = (count == core_pkg::rob_cnt_t'(`ROB_N_ENTRIES));
    assign dispatch_rob_id = tail;

    assign query1 = '{reg_ready: q1_entry.reg_ready, reg_data: q1_entry.reg_data};
    assign query2 = '{reg_ready: q2_entry.reg_ready, reg_data: q2_entry.reg_data};

    // Retire is just head ready, no mispredict or flush here
    assign retire = !rob_empty && head_entry.reg_ready;

    assign retire_info = '{
        valid: retire,
        rob_id: head,
        arf_id: head_entry.dst_arf_id,
        reg_data: head_entry.reg_data
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (dispatch) begin
                tail <= tail + 1'b1;  // Wraps with the power-of-two depth
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            count <= count + core_pkg::rob_cnt_t'(dispatch) - core_pkg::rob_cnt_t'(retire);
        end
    end

    // Dispatch and writeback never target the same live slot
    always_ff @(posedge clk) begin
        if (dispatch) begin
            entries[tail] <= dispatch_entry;
        end
        if (alu_wb.valid) begin
            entries[alu_wb.rob_id].reg_ready <= 1'b1;
            entries[alu_wb.rob_id].reg_data <= alu_wb.reg_data;
        end
        if (mul_wb.valid) begin
            entries[mul_wb.rob_id].reg_ready <= 1'b1;
            entries[mul_wb.rob_id].reg_data <= mul_wb.reg_data;
        end
    end

endmodule

// File: src/alu_exec.sv
module alu_exec (
    input  logic clk,
    input  logic reset,
    input  logic issue_valid,
    input  core_pkg::issue_t issue,
    output core_pkg::wb_t wb
);
    core_pkg::reg_data_t result;

    always_comb begin
        case (issue.op)
            core_pkg::op_add: result = issue.src1_data + issue.src2_data;
            core_pkg::op_sub: result = issue.src1_data - issue.src2_data;
            // Load-immediate arrives already zero-extended in src1
            default: result = issue.src1_data;
        endcase
    end

    // Single register stage, result and tag land together
    always_ff @(posedge clk) begin
        if (reset) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= issue_valid;
        end
        if (issue_valid) begin
            wb.rob_id <= issue.rob_id;
            wb.reg_data <= result;
        end
    end

endmodule

// File: src/mul_exec.sv
`include "core_cfg.svh"

module mul_exec (
    input  logic clk,
    input  logic reset,
    input  logic issue_valid,
    input  core_pkg::issue_t issue,
    output core_pkg::wb_t wb
);
    logic [`MUL_STAGES-1:0] vld;
    core_pkg::rob_id_t tag [`MUL_STAGES];
    logic [7:0] a_lo;
    logic [7:0] a_hi;
    logic [7:0] b_lo;
    logic [7:0] b_hi;
    core_pkg::reg_data_t pp_lo;  // Stage 1
    logic [7:0] pp_mid;          // Stage 1, only the low byte survives the shift
    core_pkg::reg_data_t sum;    // Stage 2
    core_pkg::reg_data_t product; // Stage 3

    assign {a_hi, a_lo} = issue.src1_data;
    assign {b_hi, b_lo} = issue.src2_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            vld <= '0;
        end else begin
            vld <= {vld[`MUL_STAGES-2:0], issue_valid};
        end
    end

    // High-by-high term falls outside the 16-bit result
    always_ff @(posedge clk) begin
        tag[0] <= issue.rob_id;
        for (int i = 1; i < `MUL_STAGES; i++) begin
            tag[i] <= tag[i-1];
        end
        pp_lo <= {8'h00, a_lo} * {8'h00, b_lo};
        pp_mid <= a_hi * b_lo + a_lo * b_hi;
        sum <= pp_lo + {pp_mid, 8'h00};
        product <= sum;
    end

    assign wb = '{valid: vld[`MUL_STAGES-1], rob_id: tag[`MUL_STAGES-1], reg_data: product};

endmodule

// File: src/core_top.sv
module core_top (
    input  logic clk,
    input  logic reset,

    // Instruction stream
    input  logic instr_valid,
    input  core_pkg::inst_t instr,
    output logic instr_ready,

    // Retire stream
    output logic retire,
    output core_pkg::rob_id_t retire_rob_id,
    output core_pkg::arf_id_t retire_arf_id,
    output core_pkg::reg_data_t retire_reg_data
);
    core_pkg::arf_id_t arf_src1_id;
    core_pkg::arf_id_t arf_src2_id;
    logic arf_src1_pending;
    logic arf_src2_pending;
    core_pkg::rob_id_t arf_src1_tag;
    core_pkg::rob_id_t arf_src2_tag;
    core_pkg::reg_data_t arf_src1_data;
    core_pkg::reg_data_t arf_src2_data;
    core_pkg::src_query_t rob_query1;
    core_pkg::src_query_t rob_query2;
    logic rob_full;
    logic dispatch;
    core_pkg::rob_entry_t dispatch_entry;
    core_pkg::rob_id_t dispatch_rob_id;
    logic alu_issue;
    logic mul_issue;
    core_pkg::issue_t issue;
    core_pkg::wb_t alu_wb;
    core_pkg::wb_t mul_wb;
    core_pkg::retire_t retire_info;

    inst_decode u_decode (
        .clk(clk),
        .reset(reset),
        .instr_valid(instr_valid),
        .instr(instr),
        .instr_ready(instr_ready),
        .arf_src1_id(arf_src1_id),
        .arf_src2_id(arf_src2_id),
        .arf_src1_pending(arf_src1_pending),
        .arf_src2_pending(arf_src2_pending),
        .arf_src1_tag(arf_src1_tag),
        .arf_src2_tag(arf_src2_tag),
        .arf_src1_data(arf_src1_data),
        .arf_src2_data(arf_src2_data),
        .rob_query1(rob_query1),
        .rob_query2(rob_query2),
        .rob_full(rob_full),
        .dispatch(dispatch),
        .dispatch_entry(dispatch_entry),
        .dispatch_rob_id(dispatch_rob_id),
        .alu_issue(alu_issue),
        .mul_issue(mul_issue),
        .issue(issue)
    );

    reg_file u_reg_file (
        .clk(clk),
        .reset(reset),
        .src1_id(arf_src1_id),
        .src2_id(arf_src2_id),
        .src1_pending(arf_src1_pending),
        .src2_pending(arf_src2_pending),
        .src1_tag(arf_src1_tag),
        .src2_tag(arf_src2_tag),
        .src1_data(arf_src1_data),
        .src2_data(arf_src2_data),
        .dispatch(dispatch),
        .dispatch_arf_id(dispatch_entry.dst_arf_id),
        .dispatch_rob_id(dispatch_rob_id),
        .retire_info(retire_info)
    );

    // Rename tags index the ROB read ports directly
    rob u_rob (
        .clk(clk),
        .reset(reset),
        .dispatch(dispatch),
        .dispatch_entry(dispatch_entry),
        .dispatch_rob_id(dispatch_rob_id),
        .rob_full(rob_full),
        .query1_id(arf_src1_tag),
        .query2_id(arf_src2_tag),
        .query1(rob_query1),
        .query2(rob_query2),
        .alu_wb(alu_wb),
        .mul_wb(mul_wb),
        .retire_info(retire_info)
    );

    alu_exec u_alu (
        .clk(clk),
        .reset(reset),
        .issue_valid(alu_issue),
        .issue(issue),
        .wb(alu_wb)
    );

    mul_exec u_mul (
        .clk(clk),
        .reset(reset),
        .issue_valid(mul_issue),
        .issue(issue),
        .wb(mul_wb)
    );

    assign retire = retire_info.valid;
    assign retire_rob_id = retire_info.rob_id;
    assign retire_arf_id = retire_info.arf_id;
    assign retire_reg_data = retire_info.reg_data;

endmodule

// File: dv/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // Period 20
    end

    // Held over the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// File: dv/core_checker.sv
`include "core_cfg.svh"

module core_checker (
    input  logic clk,
    input  logic reset,

    // Expected stream, one word per instruction
    input  logic [39:0] stim [64],
    input  int n_items,

    // Retire ports of the DUT
    input  logic retire,
    input  core_pkg::rob_id_t retire_rob_id,
    input  core_pkg::arf_id_t retire_arf_id,
    input  core_pkg::reg_data_t retire_reg_data,

    output int retired,
    output int errors,
    output int tests_passed,
    output int tests_failed
);
    int test_errors;
    int test_insts;
    logic [3:0] test_num;
    logic last_of_test;
    core_pkg::rob_id_t exp_rob_id;
    core_pkg::arf_id_t exp_arf_id;
    core_pkg::reg_data_t exp_data;

    task automatic compare_value(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h at instruction %0d",
                     name, got, exp, retired);
            test_errors = test_errors + 1;
            errors = errors + 1;
        end
    endtask

    task automatic close_test();
        if (test_errors == 0) begin
            tests_passed = tests_passed + 1;
        end else begin
            tests_failed = tests_failed + 1;
        end
        $display("Test %0d: %s, %0d instructions, %0d errors", test_num,
                 (test_errors == 0) ? "passed" : "failed", test_insts, test_errors);
        test_errors = 0;
        test_insts = 0;
    endtask

    // Retire strobe is stable mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            retired = 0;
            errors = 0;
            tests_passed = 0;
            tests_failed = 0;
            test_errors = 0;
            test_insts = 0;
        end else if (retire) begin
            if (retired >= n_items) begin
                $display("Error: ROB slot %0h retired after the whole stream had retired",
                         retire_rob_id);
                errors = errors + 1;
            end else begin
                test_num = stim[retired][39:36];
                exp_arf_id = stim[retired][18:16];
                exp_data = stim[retired][15:0];
                exp_rob_id = core_pkg::rob_id_t'(retired % `ROB_N_ENTRIES);  // Ids wrap
                compare_value("retire_rob_id", 16'(retire_rob_id), 16'(exp_rob_id));
                compare_value("retire_arf_id", 16'(retire_arf_id), 16'(exp_arf_id));
                compare_value("retire_reg_data", retire_reg_data, exp_data);
                test_insts = test_insts + 1;
                last_of_test = (retired == n_items - 1) ||
                               (stim[retired + 1][39:36] != test_num);
                if (last_of_test) begin
                    close_test();
                end
            end
            retired = retired + 1;
        end
    end

endmodule

// File: dv/core_tb.sv
module core_tb;
    logic clk;
    logic reset;
    logic instr_valid;
    core_pkg::inst_t instr;
    logic instr_ready;
    logic retire;
    core_pkg::rob_id_t retire_rob_id;
    core_pkg::arf_id_t retire_arf_id;
    core_pkg::reg_data_t retire_reg_data;

    logic [39:0] stim [64];  // {test, instr, dst, value}
    int n_items;
    int retired;
    int errors;
    int tests_passed;
    int tests_failed;
    int seed;
    int gap;

    tb_clock u_clock (
        .clk(clk),
        .reset(reset)
    );

    core_top dut (
        .clk(clk),
        .reset(reset),
        .instr_valid(instr_valid),
        .instr(instr),
        .instr_ready(instr_ready),
        .retire(retire),
        .retire_rob_id(retire_rob_id),
        .retire_arf_id(retire_arf_id),
        .retire_reg_data(retire_reg_data)
    );

    core_checker u_checker (
        .clk(clk),
        .reset(reset),
        .stim(stim),
        .n_items(n_items),
        .retire(retire),
        .retire_rob_id(retire_rob_id),
        .retire_arf_id(retire_arf_id),
        .retire_reg_data(retire_reg_data),
        .retired(retired),
        .errors(errors),
        .tests_passed(tests_passed),
        .tests_failed(tests_failed)
    );

    initial begin
        instr_valid = 1'b0;
        instr = '0;
        seed = 80;
        n_items = 0;
        for (int i = 0; i < 64; i++) begin
            stim[i] = '0;
        end
        $readmemh("dv/core_stimulus.txt", stim);
        while (n_items < 63 && stim[n_items][39:36] != 4'd0) begin
            n_items = n_items + 1;  // Test number zero ends the list
        end
        if (n_items == 0) begin
            $display("Error: no instructions were read from the stimulus file");
            $display("Simulation failed");
            $finish;
        end else begin
            @(negedge clk);
            while (reset) @(negedge clk);
            for (int i = 0; i < n_items; i++) begin
                gap = ($random(seed) & 32'h7fffffff) % 3;
                instr_valid = 1'b0;
                repeat (gap) @(negedge clk);
                instr_valid = 1'b1;
                instr = core_pkg::inst_t'(stim[i][35:20]);
                // Hold until the edge that takes it
                @(posedge clk);
                while (!instr_ready) @(posedge clk);
                @(negedge clk);
            end
            instr_valid = 1'b0;
            wait (retired == n_items);
            repeat (4) @(negedge clk);  // Catch stray retires
            $display("Tests passed %0d, failed %0d, retired %0d of %0d, errors %0d",
                     tests_passed, tests_failed, retired, n_items, errors);
            if (errors == 0 && tests_failed == 0 && retired == n_items) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

    // Watchdog, twelve cycles per instruction
    initial begin
        wait (n_items > 0);
        #(n_items * 12 * 20);
        $display("Error: retirement stalled, %0d of %0d instructions retired",
                 retired, n_items);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: dv/core_stimulus.txt
// One hex word per instruction, digits TIIIIDVVVV
// T test number, IIII instruction word, D expected destination, VVVV expected value
1000500005
1080A1000A
1103C2003C
1188030080
120FF400FF
1280150001
1307E6007E
138C3700C3
248201000F
291402FFD3
252402FFA6
280400005F
3DB8037F80
36DC05007F
3B720600B4
3389970099
4E24041FA4
4EEE056B94
4F4A06D6D0
4466005650
5C920100E1
5C9201C5C1
5C92019B81
5101020010
5182030020
5626040030
5AB4050010
5300160001
57EC070002
594E02002E
541000F1D1
5D9403F12E
520AB400AB
5A8805F126

// File: tb.f
+incdir+src
src/core_pkg.sv
src/inst_decode.sv
src/reg_file.sv
src/rob.sv
src/alu_exec.sv
src/mul_exec.sv
src/core_top.sv
dv/tb_clock.sv
dv/core_checker.sv
dv/core_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the ROB back end testbench with Verilator
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal -f tb.f --top-module core_tb -o core_sim \
    > build.log 2>&1 \
    && ./obj_dir/core_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or run error"; exit 1; }

cat sim.log
grep -q "^Simulation completed successfully$" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
